//--- sources.f
+incdir+.
tone_pkg.sv
key_control.sv
tempo_timer.sv
note_stepper.sv
tone_pwm.sv
scale_player.sv
scale_player_tb.sv

//--- scale_player_tb.sv
`timescale 1ns/100ps

`include "tone_defines.svh"

module scale_player_tb import tone_pkg::*; ();

    localparam int SLOW = `TONE_STEP_SLOW_CYCLES;
    localparam int FAST = `TONE_STEP_FAST_CYCLES;
    localparam int CHANGE_LIMIT = 2 * SLOW + 10;
    // Longest tone period is at the lowest note
    localparam int TONE_LIMIT = `TONE_CLK_HZ / 262 + 10;
    localparam int TOTAL_CYCLES = (3 * SLOW + 10) + (16 * SLOW + 10) + (22 * SLOW + 60)
        + (16 * SLOW + 10) + (5 * SLOW + 10) + (17 * SLOW + 4 * TONE_LIMIT + 30);

    logic       clk;
    logic       rst;
    logic       key_valid;
    scan_code_t key_code;
    logic       key_make;
    logic       tone;
    note_idx_t  note_index;

    int cycle;
    int change_count;
    int change_cycle;
    int change_from;
    int change_to;
    int checks;
    int errors;
    int test_errors;

    scale_player scale_player_inst (
        .clk        (clk),
        .rst        (rst),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .key_make   (key_make),
        .tone       (tone),
        .note_index (note_index)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Index changes are sampled away from the active edge
    always @(negedge clk) begin
        if (!rst && int'(note_index) != change_to) begin
            change_from  = change_to;
            change_to    = int'(note_index);
            change_cycle = cycle;
            change_count = change_count + 1;
        end
    end

    initial begin
        repeat (2 * TOTAL_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_eq(input integer actual, input integer expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("ERR @%0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic send_key(input scan_code_t code, input logic make);
        @(posedge clk);
        key_valid <= 1'b1;
        key_code  <= code;
        key_make  <= make;
        @(posedge clk);
        key_valid <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_change(output int cyc, output int from_v, output int to_v);
        int start;
        int n;
        start = change_count;
        n = 0;
        while (change_count == start && n < CHANGE_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (change_count == start) begin
            errors++;
            test_errors++;
            $display("Note index did not change within %0d cycles at %0t", n, $time);
        end
        cyc    = change_cycle;
        from_v = change_from;
        to_v   = change_to;
    endtask

    // Follows the walk until the target index
    // A spacing of 0 skips the timing check
    task automatic walk_to(input int target, input int step, input int spacing,
                           input string what);
        int cyc;
        int from_v;
        int to_v;
        int last_cyc;
        int n;
        n = 0;
        last_cyc = -1;
        while (change_to != target && n < 16) begin
            wait_change(cyc, from_v, to_v);
            check_eq(to_v - from_v, step, {what, " step"});
            if (spacing > 0 && last_cyc >= 0) begin
                check_eq(cyc - last_cyc, spacing, {what, " spacing"});
            end
            last_cyc = cyc;
            n++;
        end
        check_eq(change_to, target, {what, " end index"});
    endtask

    task automatic expect_hold(input int cycles, input string what);
        int start;
        start = change_count;
        repeat (cycles) @(posedge clk);
        check_eq(change_count - start, 0, what);
    endtask

    function automatic scan_code_t random_unknown_code();
        scan_code_t code;
        code = scan_code_t'($urandom % 512);
        while (code == `TONE_KEY_W || code == `TONE_KEY_S || code == `TONE_KEY_R
               || code == `TONE_KEY_F || code == `TONE_KEY_ENTER) begin
            code = scan_code_t'($urandom % 512);
        end
        return code;
    endfunction

    // C4 octave doubled for the next one with C6 on top
    function automatic int table_freq(input int idx);
        int base[7];
        base = '{262, 294, 330, 349, 392, 440, 494};
        if (idx == 14) begin
            return 1048;
        end
        return (idx >= 7) ? 2 * base[idx - 7] : base[idx];
    endfunction

    task automatic wait_tone(input logic level, output int cyc);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (tone !== level && n < TONE_LIMIT);
        if (tone !== level) begin
            errors++;
            test_errors++;
            $display("Tone never reached %b within %0d cycles at %0t", level, n, $time);
        end
        cyc = cycle;
    endtask

    // Skips the partial half-wave and then times one high and one low phase
    task automatic measure_tone(input int idx);
        int half;
        int skip;
        int rise;
        int fall;
        int rise2;
        half = `TONE_CLK_HZ / (2 * table_freq(idx));
        wait_tone(1'b0, skip);
        wait_tone(1'b1, rise);
        wait_tone(1'b0, fall);
        wait_tone(1'b1, rise2);
        check_eq(fall - rise, half, $sformatf("tone high time at index %0d", idx));
        check_eq(rise2 - fall, half, $sformatf("tone low time at index %0d", idx));
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        @(negedge clk);
        check_eq(note_index, 0, "index after reset");
        check_eq(tone, 0, "tone after reset");
        expect_hold(3 * SLOW, "index held at bottom");
        finish_test("reset and lower stop");
    endtask

    task automatic test_walk_up();
        send_key(`TONE_KEY_W, 1'b1);
        walk_to(14, 1, SLOW, "walk up");
        expect_hold(2 * SLOW, "index held at top");
        finish_test("walk up at slow tempo");
    endtask

    task automatic test_tempo();
        int cyc_a;
        int cyc_b;
        int from_v;
        int to_v;
        send_key(`TONE_KEY_S, 1'b1);
        wait_change(cyc_a, from_v, to_v);
        check_eq(to_v - from_v, -1, "step after S");
        send_key(`TONE_KEY_F, 1'b1);
        wait_change(cyc_a, from_v, to_v);
        wait_change(cyc_b, from_v, to_v);
        check_eq(cyc_b - cyc_a, FAST, "fast step spacing");
        send_key(`TONE_KEY_R, 1'b1);
        wait_change(cyc_a, from_v, to_v);
        wait_change(cyc_b, from_v, to_v);
        check_eq(cyc_b - cyc_a, SLOW, "slow step spacing");
        // W turns the walk up and none of the following may turn it back
        send_key(`TONE_KEY_W, 1'b1);
        send_key(`TONE_KEY_S, 1'b0);
        repeat (3) send_key(random_unknown_code(), 1'b1);
        walk_to(14, 1, 0, "walk up after ignored keys");
        finish_test("tempo and ignored events");
    endtask

    task automatic test_walk_down();
        send_key(`TONE_KEY_S, 1'b1);
        walk_to(0, -1, SLOW, "walk down");
        expect_hold(2 * SLOW, "index held at bottom");
        finish_test("walk down");
    endtask

    task automatic test_restart();
        int cyc;
        int from_v;
        int to_v;
        int zero_cyc;
        send_key(`TONE_KEY_W, 1'b1);
        walk_to(3, 1, SLOW, "walk before restart");
        @(posedge clk);
        key_valid <= 1'b1;
        key_code  <= `TONE_KEY_ENTER;
        key_make  <= 1'b1;
        @(posedge clk);
        key_valid <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        check_eq(note_index != '0, 1, "index two edges after Enter");
        @(negedge clk);
        check_eq(note_index, 0, "index three edges after Enter");
        zero_cyc = cycle;
        @(posedge clk);
        wait_change(cyc, from_v, to_v);
        check_eq(cyc - zero_cyc, SLOW, "first step after restart");
        check_eq(to_v, 1, "first index after restart");
        finish_test("restart");
    endtask

    task automatic test_tone();
        send_key(`TONE_KEY_S, 1'b1);
        walk_to(0, -1, 0, "walk to bottom note");
        measure_tone(0);
        send_key(`TONE_KEY_W, 1'b1);
        walk_to(14, 1, 0, "walk to top note");
        measure_tone(14);
        finish_test("tone frequency");
    endtask

    initial begin
        void'($urandom(32'h4295fcd7));
        rst          = 1'b1;
        key_valid    = 1'b0;
        key_code     = '0;
        key_make     = 1'b0;
        cycle        = 0;
        change_count = 0;
        change_cycle = 0;
        change_from  = 0;
        change_to    = 0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_walk_up();
        test_tempo();
        test_walk_down();
        test_restart();
        test_tone();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- scale_player.sv
`timescale 1ns/100ps

module scale_player import tone_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       key_valid,
    input  scan_code_t key_code,
    input  logic       key_make,
    output logic       tone,
    output note_idx_t  note_index
);

    logic dir_down;
    logic fast;
    logic restart;
    logic step_tick;

    // ------------------------------------------------------------------
    // Key commands and tempo side by side
    // ------------------------------------------------------------------
    key_control key_control_inst (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_code  (key_code),
        .key_make  (key_make),
        .dir_down  (dir_down),
        .fast      (fast),
        .restart   (restart)
    );

    tempo_timer tempo_timer_inst (
        .clk       (clk),
        .rst       (rst),
        .fast      (fast),
        .restart   (restart),
        .step_tick (step_tick)
    );

    // ------------------------------------------------------------------
    // Note walk and tone output
    // ------------------------------------------------------------------
    note_stepper note_stepper_inst (
        .clk        (clk),
        .rst        (rst),
        .step_tick  (step_tick),
        .dir_down   (dir_down),
        .restart    (restart),
        .note_index (note_index)
    );

    tone_pwm tone_pwm_inst (
        .clk        (clk),
        .rst        (rst),
        .note_index (note_index),
        .tone       (tone)
    );

endmodule

//--- tone_pwm.sv
`timescale 1ns/100ps

`include "tone_defines.svh"

module tone_pwm import tone_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  note_idx_t note_index,
    output logic      tone
);

    freq_t        note_f;
    half_period_t half_next;
    half_period_t half_q;
    half_period_t count;
    note_idx_t    prev_index;
    logic         note_change;

    // ------------------------------------------------------------------
    // Half period lookup
    // ------------------------------------------------------------------
    // Only 15 possible quotients, so this folds into a small table
    assign note_f    = note_freq(note_index);
    assign half_next = half_period_t'(`TONE_CLK_HZ / (2 * int'(note_f)));

    always_ff @(posedge clk) begin
        half_q <= half_next;
    end

    assign note_change = (note_index != prev_index);

    // ------------------------------------------------------------------
    // Square wave
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            prev_index <= '0;
            tone       <= 1'b0;
        end else begin
            prev_index <= note_index;
            if (note_change) begin
                // New note, count again from zero and keep the level
                count <= '0;
            end else if (count == half_q - half_period_t'(1)) begin
                count <= '0;
                tone  <= ~tone;
            end else begin
                count <= count + half_period_t'(1);
            end
        end
    end

    // Holds because a new half period always comes with a cleared count
    count_below_half: assert property (
        @(posedge clk) disable iff (rst) count < half_q
    );

endmodule

//--- note_stepper.sv
`timescale 1ns/100ps

`include "tone_defines.svh"

module note_stepper import tone_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      step_tick,
    input  logic      dir_down,
    input  logic      restart,
    output note_idx_t note_index
);

    localparam note_idx_t TOP_INDEX = note_idx_t'(`TONE_NOTE_COUNT - 1);

    logic at_top;
    logic at_bottom;

    assign at_top    = (note_index == TOP_INDEX);
    assign at_bottom = (note_index == '0);

    // ------------------------------------------------------------------
    // Saturating up/down index
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            note_index <= '0;
        end else if (restart) begin
            // Restart wins over a tick in the same cycle
            note_index <= '0;
        end else if (step_tick) begin
            if (dir_down) begin
                if (!at_bottom) begin
                    note_index <= note_index - note_idx_t'(1);
                end
            end else begin
                if (!at_top) begin
                    note_index <= note_index + note_idx_t'(1);
                end
            end
        end
    end

    // Index must stay inside the note table
    index_in_table: assert property (
        @(posedge clk) disable iff (rst) note_index <= TOP_INDEX
    );

endmodule

//--- tempo_timer.sv
`timescale 1ns/100ps

`include "tone_defines.svh"

module tempo_timer import tone_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic fast,
    input  logic restart,
    output logic step_tick
);

    step_count_t count;
    step_count_t period;
    step_count_t period_sel;

    assign period_sel = fast ? step_count_t'(`TONE_STEP_FAST_CYCLES)
                             : step_count_t'(`TONE_STEP_SLOW_CYCLES);

    // Tick on the last count of the running period
    assign step_tick = (count == period - step_count_t'(1));

    // ------------------------------------------------------------------
    // Step counter
    // ------------------------------------------------------------------
    // Period only follows the tempo flag at a wrap or a restart,
    // so a tempo change never cuts a step short
    always_ff @(posedge clk) begin
        if (rst) begin
            count  <= '0;
            period <= step_count_t'(`TONE_STEP_SLOW_CYCLES);
        end else if (restart || step_tick) begin
            count  <= '0;
            period <= period_sel;
        end else begin
            count <= count + step_count_t'(1);
        end
    end

    // The slow period bounds both tempos
    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
            count < step_count_t'(`TONE_STEP_SLOW_CYCLES)
    );

endmodule

//--- key_control.sv
`timescale 1ns/100ps

`include "tone_defines.svh"

module key_control import tone_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       key_valid,
    input  scan_code_t key_code,
    input  logic       key_make,
    output logic       dir_down,
    output logic       fast,
    output logic       restart
);

    key_state_t state;
    scan_code_t code_q;
    logic       take;

    // Release events are dropped here
    assign take = key_valid && key_make;

    // Latched code, applied in the cycle after the event
    always_ff @(posedge clk) begin
        if (take) begin
            code_q <= key_code;
        end
    end

    // ------------------------------------------------------------------
    // Idle/apply machine
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= KEY_IDLE;
            dir_down <= 1'b1;
            fast     <= 1'b0;
            restart  <= 1'b0;
        end else begin
            restart <= 1'b0;
            if (state == KEY_APPLY) begin
                case (code_q)
                    `TONE_KEY_W:     dir_down <= 1'b0;
                    `TONE_KEY_S:     dir_down <= 1'b1;
                    `TONE_KEY_R:     fast     <= 1'b0;
                    `TONE_KEY_F:     fast     <= 1'b1;
                    `TONE_KEY_ENTER: restart  <= 1'b1;
                    default: begin
                        // Unknown code, nothing changes
                    end
                endcase
            end
            // An event arriving during apply keeps the machine in apply
            state <= take ? KEY_APPLY : KEY_IDLE;
        end
    end

    // Restart is a single pulse per Enter event
    restart_single_pulse: assert property (
        @(posedge clk) disable iff (rst) restart |=> !restart
    );

endmodule

//--- tone_pkg.sv
package tone_pkg;

    // Extended-prefix flag plus 8-bit code
    typedef logic [8:0] scan_code_t;

    // Index into the note table, 0 to 14
    typedef logic [3:0] note_idx_t;

    // Note frequency in Hz, up to 1048
    typedef logic [10:0] freq_t;

    // Tone half period in clock cycles
    typedef logic [19:0] half_period_t;

    // Tempo counter
    typedef logic [15:0] step_count_t;

    typedef enum logic {
        KEY_IDLE,
        KEY_APPLY
    } key_state_t;

    // ------------------------------------------------------------------
    // Note table lookup
    // ------------------------------------------------------------------
    // Second octave is the first one doubled, top entry is C6
    function automatic freq_t note_freq(input note_idx_t idx);
        freq_t f;
        case (idx)
            4'd0:    f = 11'd262;
            4'd1:    f = 11'd294;
            4'd2:    f = 11'd330;
            4'd3:    f = 11'd349;
            4'd4:    f = 11'd392;
            4'd5:    f = 11'd440;
            4'd6:    f = 11'd494;
            4'd7:    f = 11'd524;
            4'd8:    f = 11'd588;
            4'd9:    f = 11'd660;
            4'd10:   f = 11'd698;
            4'd11:   f = 11'd784;
            4'd12:   f = 11'd880;
            4'd13:   f = 11'd988;
            default: f = 11'd1048;
        endcase
        return f;
    endfunction

endpackage

//--- tone_defines.svh
`ifndef TONE_DEFINES_SVH
`define TONE_DEFINES_SVH

// ----------------------------------------------------------------------
// Clock and tempo
// ----------------------------------------------------------------------

// Kept small so that tone periods stay short in simulation
`define TONE_CLK_HZ 1000000

// Step periods in clock cycles
`define TONE_STEP_SLOW_CYCLES 40
`define TONE_STEP_FAST_CYCLES 20

// Entries in the note table, C4 up to C6
`define TONE_NOTE_COUNT 15

// ----------------------------------------------------------------------
// Key scan codes (extended flag in bit 8)
// ----------------------------------------------------------------------
`define TONE_KEY_W 9'd29
`define TONE_KEY_S 9'd27
`define TONE_KEY_R 9'd45
`define TONE_KEY_F 9'd43
`define TONE_KEY_ENTER 9'd90

`endif
